//--- verilog/issue_macros.svh
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// Datapath widths
`define XLEN            64
`define ILEN            32

// Physical register file
`define PREG_BITS       6
`define NUM_PREG        64
`define ZERO_REG        6'd31

// Reservation station
`define RS_DEPTH        16
`define RS_IDX_BITS     4

// Branch tracking
`define BR_DEPTH        4
`define BR_MARKER_BITS  3
`define BR_MARKER_EMPTY 3'd7

// Function codes and the Alpha no-op
`define ALU_FUNC_BITS   5
`define ALU_MULQ        5'h0b
`define NOOP_INST       32'h47ff041f

`endif

//--- verilog/issue_pkg.sv
`include "issue_macros.svh"

package issue_pkg;

  // One reservation-station entry as read out at grant time
  typedef struct packed {
    logic [`ILEN-1:0]           inst;
    logic [`XLEN-1:0]           npc;
    logic [`PREG_BITS-1:0]      opa_idx;
    logic [`PREG_BITS-1:0]      opb_idx;
    logic [`PREG_BITS-1:0]      dest_idx;
    logic [1:0]                 opa_select;
    logic [1:0]                 opb_select;
    logic [`ALU_FUNC_BITS-1:0]  alu_func;
    logic                       rd_mem;
    logic                       wr_mem;
    logic                       cond_branch;
    logic                       uncond_branch;
    logic [`BR_MARKER_BITS-1:0] br_marker;
    logic [`BR_DEPTH-1:0]       bmask;
  } rs_entry_t;

  typedef struct packed {
    logic                    valid;
    logic [`RS_IDX_BITS-1:0] idx;
  } rs_grant_t;

  // Branch resolved by execute this cycle
  typedef struct packed {
    logic                       valid;
    logic [`BR_MARKER_BITS-1:0] marker;
  } br_resolve_t;

  typedef struct packed {
    logic                  en;
    logic [`PREG_BITS-1:0] idx;
    logic [`XLEN-1:0]      data;
  } wb_port_t;

  // Bundle handed to one functional unit
  typedef struct packed {
    logic                       valid;
    logic [`ILEN-1:0]           inst;
    logic [`XLEN-1:0]           npc;
    logic [`XLEN-1:0]           rega;
    logic [`XLEN-1:0]           regb;
    logic [`PREG_BITS-1:0]      dest_idx;
    logic [1:0]                 opa_select;
    logic [1:0]                 opb_select;
    logic [`ALU_FUNC_BITS-1:0]  alu_func;
    logic                       rd_mem;
    logic                       wr_mem;
    logic                       cond_branch;
    logic                       uncond_branch;
    logic [`BR_MARKER_BITS-1:0] br_marker;
    logic [`BR_DEPTH-1:0]       bmask;
  } unit_issue_t;

endpackage

//--- verilog/issue_select.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_select (
  input  logic [`RS_DEPTH-1:0] rs_ready,
  input  logic                 exec_ready,
  output issue_pkg::rs_grant_t grant_1,
  output issue_pkg::rs_grant_t grant_2
);

  logic                    first_found;
  logic                    second_found;
  logic [`RS_IDX_BITS-1:0] first_idx;
  logic [`RS_IDX_BITS-1:0] second_idx;

  // Priority scan from the lowest index
  always_comb
  begin
    first_found  = 1'b0;
    second_found = 1'b0;
    first_idx    = '0;
    second_idx   = '0;
    for (int i = 0; i < `RS_DEPTH; i++)
    begin
      if (rs_ready[i])
      begin
        if (!first_found)
        begin
          first_found = 1'b1;
          first_idx   = i[`RS_IDX_BITS-1:0];
        end
        else if (!second_found)
        begin
          second_found = 1'b1;
          second_idx   = i[`RS_IDX_BITS-1:0];
        end
      end
    end
  end

  // Execute stall holds back both grants
  always_comb
  begin
    grant_1.valid = first_found && exec_ready;
    grant_1.idx   = grant_1.valid ? first_idx : '0;
    grant_2.valid = second_found && exec_ready;
    grant_2.idx   = grant_2.valid ? second_idx : '0;
  end

endmodule

//--- verilog/issue_regfile.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_regfile (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`PREG_BITS-1:0] rda_idx_1,
  input  logic [`PREG_BITS-1:0] rdb_idx_1,
  input  logic [`PREG_BITS-1:0] rda_idx_2,
  input  logic [`PREG_BITS-1:0] rdb_idx_2,
  input  issue_pkg::wb_port_t   wb_1,
  input  issue_pkg::wb_port_t   wb_2,
  output logic [`XLEN-1:0]      rda_1,
  output logic [`XLEN-1:0]      rdb_1,
  output logic [`XLEN-1:0]      rda_2,
  output logic [`XLEN-1:0]      rdb_2
);

  logic [`XLEN-1:0] regs [`NUM_PREG];

  // Four combinational read ports, zero register reads as zero
  assign rda_1 = (rda_idx_1 == `ZERO_REG) ? '0 : regs[rda_idx_1];
  assign rdb_1 = (rdb_idx_1 == `ZERO_REG) ? '0 : regs[rdb_idx_1];
  assign rda_2 = (rda_idx_2 == `ZERO_REG) ? '0 : regs[rda_idx_2];
  assign rdb_2 = (rdb_idx_2 == `ZERO_REG) ? '0 : regs[rdb_idx_2];

  // Port 2 is written last so it wins a same-index collision
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `NUM_PREG; i++)
      begin
        regs[i] <= '0;
      end
    end
    else
    begin
      if (wb_1.en && (wb_1.idx != `ZERO_REG))
      begin
        regs[wb_1.idx] <= wb_1.data;
      end
      if (wb_2.en && (wb_2.idx != `ZERO_REG))
      begin
        regs[wb_2.idx] <= wb_2.data;
      end
    end
  end

endmodule

//--- verilog/issue_slot.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_slot (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   grant_valid,
  input  issue_pkg::rs_entry_t   entry,
  input  logic [`XLEN-1:0]       rega,
  input  logic [`XLEN-1:0]       regb,
  input  issue_pkg::br_resolve_t br_resolve_1,
  input  issue_pkg::br_resolve_t br_resolve_2,
  output issue_pkg::unit_issue_t alu,
  output issue_pkg::unit_issue_t mul
);

  import issue_pkg::*;

  logic [`BR_DEPTH-1:0] bmask_clr;
  logic                 is_mul;
  unit_issue_t          issue_bundle;
  unit_issue_t          alu_d;
  unit_issue_t          mul_d;

  // Bundle seen by a unit with nothing to do
  function automatic unit_issue_t idle_unit();
    unit_issue_t idle;
    idle           = '0;
    idle.inst      = `NOOP_INST;
    idle.br_marker = `BR_MARKER_EMPTY;
    return idle;
  endfunction

  // Drop dependence on branches resolving this cycle
  always_comb
  begin
    bmask_clr = entry.bmask;
    for (int b = 0; b < `BR_DEPTH; b++)
    begin
      if (br_resolve_1.valid && (br_resolve_1.marker == `BR_MARKER_BITS'(b)))
      begin
        bmask_clr[b] = 1'b0;
      end
      if (br_resolve_2.valid && (br_resolve_2.marker == `BR_MARKER_BITS'(b)))
      begin
        bmask_clr[b] = 1'b0;
      end
    end
  end

  always_comb
  begin
    issue_bundle.valid         = 1'b1;
    issue_bundle.inst          = entry.inst;
    issue_bundle.npc           = entry.npc;
    issue_bundle.rega          = rega;
    issue_bundle.regb          = regb;
    issue_bundle.dest_idx      = entry.dest_idx;
    issue_bundle.opa_select    = entry.opa_select;
    issue_bundle.opb_select    = entry.opb_select;
    issue_bundle.alu_func      = entry.alu_func;
    issue_bundle.rd_mem        = entry.rd_mem;
    issue_bundle.wr_mem        = entry.wr_mem;
    issue_bundle.cond_branch   = entry.cond_branch;
    issue_bundle.uncond_branch = entry.uncond_branch;
    issue_bundle.br_marker     = entry.br_marker;
    issue_bundle.bmask         = bmask_clr;
  end

  // MULQ goes to the multiplier and all else to the simple ALU
  assign is_mul = (entry.alu_func == `ALU_MULQ);
  assign alu_d  = (grant_valid && !is_mul) ? issue_bundle : idle_unit();
  assign mul_d  = (grant_valid && is_mul) ? issue_bundle : idle_unit();

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      alu <= idle_unit();
      mul <= idle_unit();
    end
    else
    begin
      alu <= alu_d;
      mul <= mul_d;
    end
  end

endmodule

//--- verilog/issue_stage.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`RS_DEPTH-1:0]   rs_ready,
  input  logic                   exec_ready,
  input  issue_pkg::rs_entry_t   entry_1,
  input  issue_pkg::rs_entry_t   entry_2,
  input  issue_pkg::br_resolve_t br_resolve_1,
  input  issue_pkg::br_resolve_t br_resolve_2,
  input  issue_pkg::wb_port_t    wb_1,
  input  issue_pkg::wb_port_t    wb_2,
  output issue_pkg::rs_grant_t   grant_1,
  output issue_pkg::rs_grant_t   grant_2,
  output issue_pkg::unit_issue_t alu0,
  output issue_pkg::unit_issue_t mul0,
  output issue_pkg::unit_issue_t alu1,
  output issue_pkg::unit_issue_t mul1
);

  logic [`XLEN-1:0] rega_1;
  logic [`XLEN-1:0] regb_1;
  logic [`XLEN-1:0] rega_2;
  logic [`XLEN-1:0] regb_2;

  issue_select u_select (
    .rs_ready   (rs_ready),
    .exec_ready (exec_ready),
    .grant_1    (grant_1),
    .grant_2    (grant_2)
  );

  // Operands read in the grant cycle
  issue_regfile u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .rda_idx_1 (entry_1.opa_idx),
    .rdb_idx_1 (entry_1.opb_idx),
    .rda_idx_2 (entry_2.opa_idx),
    .rdb_idx_2 (entry_2.opb_idx),
    .wb_1      (wb_1),
    .wb_2      (wb_2),
    .rda_1     (rega_1),
    .rdb_1     (regb_1),
    .rda_2     (rega_2),
    .rdb_2     (regb_2)
  );

  // Slot 1 takes the lower RS index
  issue_slot u_slot_1 (
    .clk          (clk),
    .rst_n        (rst_n),
    .grant_valid  (grant_1.valid),
    .entry        (entry_1),
    .rega         (rega_1),
    .regb         (regb_1),
    .br_resolve_1 (br_resolve_1),
    .br_resolve_2 (br_resolve_2),
    .alu          (alu0),
    .mul          (mul0)
  );

  issue_slot u_slot_2 (
    .clk          (clk),
    .rst_n        (rst_n),
    .grant_valid  (grant_2.valid),
    .entry        (entry_2),
    .rega         (rega_2),
    .regb         (regb_2),
    .br_resolve_1 (br_resolve_1),
    .br_resolve_2 (br_resolve_2),
    .alu          (alu1),
    .mul          (mul1)
  );

endmodule

//--- verification/issue_tb_clk.sv
`timescale 1ns/1ps

module issue_tb_clk #(
  parameter int unsigned PERIOD_NS = 100
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
  end

  // Free-running clock with 50 percent duty
  always
  begin
    #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

//--- verification/issue_assert.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_assert (
  input logic                   clk,
  input logic                   rst_n,
  input logic [`RS_DEPTH-1:0]   rs_ready,
  input logic                   exec_ready,
  input issue_pkg::rs_entry_t   entry_1,
  input issue_pkg::rs_entry_t   entry_2,
  input issue_pkg::br_resolve_t br_resolve_1,
  input issue_pkg::br_resolve_t br_resolve_2,
  input issue_pkg::wb_port_t    wb_1,
  input issue_pkg::wb_port_t    wb_2,
  input issue_pkg::rs_grant_t   grant_1,
  input issue_pkg::rs_grant_t   grant_2,
  input issue_pkg::unit_issue_t alu0,
  input issue_pkg::unit_issue_t mul0,
  input issue_pkg::unit_issue_t alu1,
  input issue_pkg::unit_issue_t mul1
);

  import issue_pkg::*;

  bit                      failed = 1'b0;
  logic [`XLEN-1:0]        shadow [`NUM_PREG];
  logic                    found_1;
  logic                    found_2;
  logic [`RS_IDX_BITS-1:0] low_1;
  logic [`RS_IDX_BITS-1:0] low_2;
  unit_issue_t             exp_1;
  unit_issue_t             exp_2;

  function automatic unit_issue_t idle_unit();
    unit_issue_t u;
    u           = '0;
    u.inst      = `NOOP_INST;
    u.br_marker = `BR_MARKER_EMPTY;
    return u;
  endfunction

  function automatic logic [`XLEN-1:0] shadow_read(input logic [`PREG_BITS-1:0] idx);
    logic [`XLEN-1:0] v;
    v = (idx == `ZERO_REG) ? '0 : shadow[idx];
    return v;
  endfunction

  // Bundle that a granted entry should produce one cycle later
  function automatic unit_issue_t expected_bundle(input rs_entry_t e,
                                                  input br_resolve_t r1,
                                                  input br_resolve_t r2);
    unit_issue_t u;
    u               = '0;
    u.valid         = 1'b1;
    u.inst          = e.inst;
    u.npc           = e.npc;
    u.rega          = shadow_read(e.opa_idx);
    u.regb          = shadow_read(e.opb_idx);
    u.dest_idx      = e.dest_idx;
    u.opa_select    = e.opa_select;
    u.opb_select    = e.opb_select;
    u.alu_func      = e.alu_func;
    u.rd_mem        = e.rd_mem;
    u.wr_mem        = e.wr_mem;
    u.cond_branch   = e.cond_branch;
    u.uncond_branch = e.uncond_branch;
    u.br_marker     = e.br_marker;
    u.bmask         = e.bmask;
    if (r1.valid && !r1.marker[2])
    begin
      u.bmask[r1.marker[1:0]] = 1'b0;
    end
    if (r2.valid && !r2.marker[2])
    begin
      u.bmask[r2.marker[1:0]] = 1'b0;
    end
    return u;
  endfunction

  // Shadow register file with the second port written last
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `NUM_PREG; i++)
      begin
        shadow[i] <= '0;
      end
    end
    else
    begin
      if (wb_1.en && (wb_1.idx != `ZERO_REG))
      begin
        shadow[wb_1.idx] <= wb_1.data;
      end
      if (wb_2.en && (wb_2.idx != `ZERO_REG))
      begin
        shadow[wb_2.idx] <= wb_2.data;
      end
    end
  end

  always_comb
  begin
    found_1 = 1'b0;
    found_2 = 1'b0;
    low_1   = '0;
    low_2   = '0;
    for (int i = `RS_DEPTH - 1; i >= 0; i--)
    begin
      if (rs_ready[i])
      begin
        found_2 = found_1;
        low_2   = low_1;
        found_1 = 1'b1;
        low_1   = i[`RS_IDX_BITS-1:0];
      end
    end
    exp_1 = expected_bundle(entry_1, br_resolve_1, br_resolve_2);
    exp_2 = expected_bundle(entry_2, br_resolve_1, br_resolve_2);
  end

  a_reset_grants: assert property (@(posedge clk)
    (!rst_n || $past(!rst_n)) |-> (!grant_1.valid && !grant_2.valid))
  else
  begin
    failed = 1'b1;
    $error("ERR %0t: grant valid around reset", $time);
  end

  a_reset_idle: assert property (@(posedge clk)
    !rst_n |=> (alu0 == idle_unit() && mul0 == idle_unit() &&
                alu1 == idle_unit() && mul1 == idle_unit()))
  else
  begin
    failed = 1'b1;
    $error("ERR %0t: unit not idle after reset", $time);
  end

  a_grant_1: assert property (@(posedge clk) disable iff (!rst_n)
    (grant_1.valid == (found_1 && exec_ready)) && (!grant_1.valid || grant_1.idx == low_1))
  else
  begin
    failed = 1'b1;
    $error("ERR %0t: grant_1 not lowest ready", $time);
  end

  a_grant_2: assert property (@(posedge clk) disable iff (!rst_n)
    (grant_2.valid == (found_2 && exec_ready)) && (!grant_2.valid || grant_2.idx == low_2))
  else
  begin
    failed = 1'b1;
    $error("ERR %0t: grant_2 not next ready", $time);
  end

  a_slot_1: assert property (@(posedge clk) disable iff (!rst_n)
    $past(grant_1.valid)
      ? (($past(entry_1.alu_func) == `ALU_MULQ)
          ? (mul0 == $past(exp_1) && alu0 == idle_unit())
          : (alu0 == $past(exp_1) && mul0 == idle_unit()))
      : (alu0 == idle_unit() && mul0 == idle_unit()))
  else
  begin
    failed = 1'b1;
    $error("ERR %0t: slot 1 bundle mismatch", $time);
  end

  a_slot_2: assert property (@(posedge clk) disable iff (!rst_n)
    $past(grant_2.valid)
      ? (($past(entry_2.alu_func) == `ALU_MULQ)
          ? (mul1 == $past(exp_2) && alu1 == idle_unit())
          : (alu1 == $past(exp_2) && mul1 == idle_unit()))
      : (alu1 == idle_unit() && mul1 == idle_unit()))
  else
  begin
    failed = 1'b1;
    $error("ERR %0t: slot 2 bundle mismatch", $time);
  end

endmodule

bind issue_stage issue_assert u_assert (.*);

//--- verification/issue_tb.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_tb;

  import issue_pkg::*;

  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned TEST_CYCLES  = 2000;
  localparam int unsigned LIMIT_CYCLES = 2100;

  logic                 clk;
  logic                 rst_n;
  logic [`RS_DEPTH-1:0] rs_ready;
  logic                 exec_ready;
  rs_entry_t            entry_1;
  rs_entry_t            entry_2;
  br_resolve_t          br_resolve_1;
  br_resolve_t          br_resolve_2;
  wb_port_t             wb_1;
  wb_port_t             wb_2;
  rs_grant_t            grant_1;
  rs_grant_t            grant_2;
  unit_issue_t          alu0;
  unit_issue_t          mul0;
  unit_issue_t          alu1;
  unit_issue_t          mul1;

  rs_entry_t   rs_model [`RS_DEPTH];
  logic [31:0] rng_state = 32'hcbc7_4194;

  issue_tb_clk #(.PERIOD_NS(100)) u_clk (.clk(clk));

  issue_stage i_issue_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .rs_ready     (rs_ready),
    .exec_ready   (exec_ready),
    .entry_1      (entry_1),
    .entry_2      (entry_2),
    .br_resolve_1 (br_resolve_1),
    .br_resolve_2 (br_resolve_2),
    .wb_1         (wb_1),
    .wb_2         (wb_2),
    .grant_1      (grant_1),
    .grant_2      (grant_2),
    .alu0         (alu0),
    .mul0         (mul0),
    .alu1         (alu1),
    .mul1         (mul1)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r         = rng_state;
  endtask

  // Random entry where roughly a third are multiplies
  task automatic random_entry(output rs_entry_t e);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    next_rand(r0);
    next_rand(r1);
    next_rand(r2);
    next_rand(r3);
    e               = '0;
    e.inst          = r0;
    e.npc           = {r1, r2};
    e.opa_idx       = (r3[1:0] == 2'd0) ? `ZERO_REG : r3[7:2];
    e.opb_idx       = r3[13:8];
    e.dest_idx      = r3[19:14];
    e.opa_select    = r2[1:0];
    e.opb_select    = r2[3:2];
    e.alu_func      = (r3[27:20] % 8'd3 == 8'd0) ? `ALU_MULQ : {1'b1, r1[3:0]};
    e.rd_mem        = r0[28];
    e.wr_mem        = r0[29];
    e.cond_branch   = r0[30];
    e.uncond_branch = r0[31];
    e.br_marker     = r3[30:28];
    e.bmask         = r1[7:4];
  endtask

  // Reservation-station read-out follows the grants
  always_comb
  begin
    entry_1 = rs_model[grant_1.idx];
    entry_2 = rs_model[grant_2.idx];
  end

  always @(i_issue_stage.u_assert.failed)
  begin
    if (i_issue_stage.u_assert.failed)
    begin
      $display("Testbench failed");
      $fatal(1, "An assertion on the issue stage failed");
    end
  end

  initial
  begin
    #(LIMIT_CYCLES * 100);
    $display("Testbench failed");
    $fatal(1, "Watchdog expired before the test finished");
  end

  initial
  begin
    rs_entry_t   e;
    logic [31:0] r;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] d2;
    logic [31:0] d3;
    rst_n        <= 1'b0;
    rs_ready     <= '0;
    exec_ready   <= 1'b0;
    br_resolve_1 <= '0;
    br_resolve_2 <= '0;
    wb_1         <= '0;
    wb_2         <= '0;
    for (int i = 0; i < `RS_DEPTH; i++)
    begin
      random_entry(e);
      rs_model[i] <= e;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int c = 0; c < TEST_CYCLES; c++)
    begin
      // Granted entries leave the station and are replaced
      if (grant_1.valid)
      begin
        random_entry(e);
        rs_model[grant_1.idx] <= e;
      end
      if (grant_2.valid)
      begin
        random_entry(e);
        rs_model[grant_2.idx] <= e;
      end
      next_rand(r);
      rs_ready   <= r[15:0];
      exec_ready <= (r[23:16] % 8'd10) < 8'd8;
      br_resolve_1.valid  <= r[24];
      br_resolve_1.marker <= r[27:25];
      br_resolve_2.valid  <= r[28];
      br_resolve_2.marker <= r[31:29];
      next_rand(r);
      next_rand(d0);
      next_rand(d1);
      next_rand(d2);
      next_rand(d3);
      wb_1.en   <= r[0];
      wb_1.idx  <= (r[3:1] == 3'd0) ? `ZERO_REG : r[9:4];
      wb_1.data <= {d0, d1};
      wb_2.en   <= r[10];
      wb_2.idx  <= (r[12:11] == 2'd0) ? ((r[3:1] == 3'd0) ? `ZERO_REG : r[9:4]) : r[18:13];
      wb_2.data <= {d2, d3};
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    if (i_issue_stage.u_assert.failed)
    begin
      $display("Testbench failed");
      $fatal(1, "An assertion on the issue stage failed");
    end
    else
    begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

//--- tb.f
+incdir+verilog
verilog/issue_pkg.sv
verilog/issue_select.sv
verilog/issue_regfile.sv
verilog/issue_slot.sv
verilog/issue_stage.sv
verification/issue_tb_clk.sv
verification/issue_assert.sv
verification/issue_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module issue_tb -o issue_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/issue_tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
fi

grep -q "^Testbench passed$" sim.log
if [ $? -ne 0 ]; then
  echo "Pass message not found in sim.log"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  exit 1
fi

exit 0
